// File: decoder.f
+incdir+sim
src/rv32_pkg.sv
src/decode_fmt_i.sv
src/decode_fmt_r.sv
src/decode_fmt_s.sv
src/decode_fmt_b.sv
src/decode_fmt_uj.sv
src/decoder.sv
sim/decoder_tb.sv

// File: sim/decoder_tb_vectors.svh
`ifndef DECODER_TB_VECTORS_SVH
`define DECODER_TB_VECTORS_SVH

// columns: {rdy,issue,hit}, pc, instruction,
// then expected pc, op, imm, {en_rx,en_ry,en_w}, rs1, rs2, rd.
task automatic load_vectors();
    // held reset state, nothing issued yet.
    add_vector(3'b100, 32'h0000_0000, 32'h0000_0000,
               32'h0000_0000, rv32_pkg::OP_NOP, 32'h0000_0000, 3'b000, 0, 0, 0);
    add_vector(3'b111, 32'h0000_0100, 32'hFFD3_0293,
               32'h0000_0100, rv32_pkg::OP_ADDI, 32'hFFFF_FFFD, 3'b101, 6, 0, 5);
    add_vector(3'b111, 32'h0000_0104, 32'h4044_5393,
               32'h0000_0104, rv32_pkg::OP_SRAI, 32'h0000_0404, 3'b101, 8, 0, 7);
    add_vector(3'b111, 32'h0000_0108, 32'h0081_2503,
               32'h0000_0108, rv32_pkg::OP_LW, 32'h0000_0008, 3'b101, 2, 0, 10);
    add_vector(3'b111, 32'h0000_010C, 32'hFFF1_C583,
               32'h0000_010C, rv32_pkg::OP_LBU, 32'hFFFF_FFFF, 3'b101, 3, 0, 11);
    add_vector(3'b111, 32'h0000_0110, 32'h0031_00B3,
               32'h0000_0110, rv32_pkg::OP_ADD, 32'h0000_0000, 3'b111, 2, 3, 1);
    add_vector(3'b111, 32'h0000_0114, 32'h4062_8233,
               32'h0000_0114, rv32_pkg::OP_SUB, 32'h0000_0000, 3'b111, 5, 6, 4);
    add_vector(3'b111, 32'h0000_0118, 32'h40B5_54B3,
               32'h0000_0118, rv32_pkg::OP_SRA, 32'h0000_0000, 3'b111, 10, 11, 9);
    add_vector(3'b111, 32'h0000_011C, 32'hFE74_2E23,
               32'h0000_011C, rv32_pkg::OP_SW, 32'hFFFF_FFFC, 3'b110, 8, 7, 0);
    add_vector(3'b111, 32'h0000_0120, 32'hFE20_9CE3,
               32'h0000_0120, rv32_pkg::OP_BNE, 32'hFFFF_FFF8, 3'b110, 1, 2, 0);
    add_vector(3'b111, 32'h0000_0124, 32'h1234_52B7,
               32'h0000_0124, rv32_pkg::OP_LUI, 32'h1234_5000, 3'b001, 0, 0, 5);
    add_vector(3'b111, 32'h0000_0128, 32'hFFFF_F317,
               32'h0000_0128, rv32_pkg::OP_AUIPC, 32'hFFFF_F000, 3'b001, 0, 0, 6);
    add_vector(3'b111, 32'h0000_012C, 32'hFFDF_F0EF,
               32'h0000_012C, rv32_pkg::OP_JAL, 32'hFFFF_FFFC, 3'b001, 0, 0, 1);
    add_vector(3'b111, 32'h0000_0130, 32'h00C2_80E7,
               32'h0000_0130, rv32_pkg::OP_JALR, 32'h0000_000C, 3'b101, 5, 0, 1);
    // illegal: funct7 0x01, branch funct3 2, fence, jalr funct3 1.
    add_vector(3'b111, 32'h0000_0134, 32'h0231_00B3,
               32'h0000_0134, rv32_pkg::OP_NOP, 32'h0000_0000, 3'b000, 0, 0, 0);
    add_vector(3'b111, 32'h0000_0138, 32'h0020_A463,
               32'h0000_0138, rv32_pkg::OP_NOP, 32'h0000_0000, 3'b000, 0, 0, 0);
    add_vector(3'b111, 32'h0000_013C, 32'h0FF0_000F,
               32'h0000_013C, rv32_pkg::OP_NOP, 32'h0000_0000, 3'b000, 0, 0, 0);
    add_vector(3'b111, 32'h0000_0140, 32'h00C2_90E7,
               32'h0000_0140, rv32_pkg::OP_NOP, 32'h0000_0000, 3'b000, 0, 0, 0);
    // a miss loads the bubble at pc 0.
    add_vector(3'b110, 32'h0000_0144, 32'h0031_00B3,
               32'h0000_0000, rv32_pkg::OP_ADDI, 32'h0000_0000, 3'b101, 0, 0, 0);
    add_vector(3'b111, 32'h0000_0148, 32'h0556_C613,
               32'h0000_0148, rv32_pkg::OP_XORI, 32'h0000_0055, 3'b101, 13, 0, 12);
    // stalls keep the xori record.
    add_vector(3'b011, 32'h0000_014C, 32'h0031_00B3,
               32'h0000_0148, rv32_pkg::OP_XORI, 32'h0000_0055, 3'b101, 13, 0, 12);
    add_vector(3'b101, 32'h0000_0150, 32'h4062_8233,
               32'h0000_0148, rv32_pkg::OP_XORI, 32'h0000_0055, 3'b101, 13, 0, 12);
    add_vector(3'b010, 32'h0000_0154, 32'h0000_0013,
               32'h0000_0148, rv32_pkg::OP_XORI, 32'h0000_0055, 3'b101, 13, 0, 12);
    add_vector(3'b111, 32'h0000_0158, 32'h01F1_9113,
               32'h0000_0158, rv32_pkg::OP_SLLI, 32'h0000_001F, 3'b101, 3, 0, 2);
endtask

`endif

// File: sim/decoder_tb.sv
module decoder_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // ctl holds {rdy, issue, hit} for one row.
    typedef struct packed {
        logic [2:0]         ctl;
        rv32_pkg::addr_t    pc;
        rv32_pkg::inst_t    inst;
        rv32_pkg::dec_out_t want;
    } vector_t;

    logic               clk;
    logic               rst;
    logic               rdy_i;
    logic               issue_i;
    logic               hit_i;
    rv32_pkg::addr_t    pc_i;
    rv32_pkg::inst_t    inst_i;
    rv32_pkg::dec_out_t dec_o;

    vector_t vectors[$];
    int      row_errors;
    int      pass_count;
    int      fail_count;
    int      cycle_count;
    int      cycle_limit;

    decoder u_decoder (
        .clk     (clk),
        .rst     (rst),
        .rdy_i   (rdy_i),
        .issue_i (issue_i),
        .hit_i   (hit_i),
        .pc_i    (pc_i),
        .inst_i  (inst_i),
        .dec_o   (dec_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: decode table did not finish");
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic add_vector(input logic [2:0] ctl, input rv32_pkg::addr_t pc,
                              input rv32_pkg::inst_t inst, input rv32_pkg::addr_t exp_pc,
                              input rv32_pkg::oper_t op, input rv32_pkg::word_t imm,
                              input logic [2:0] en, input rv32_pkg::regaddr_t rs1,
                              input rv32_pkg::regaddr_t rs2, input rv32_pkg::regaddr_t rd);
        vector_t v;
        v.ctl        = ctl;
        v.pc         = pc;
        v.inst       = inst;
        v.want.pc    = exp_pc;
        v.want.op    = op;
        v.want.imm   = imm;
        v.want.en_rx = en[2];
        v.want.en_ry = en[1];
        v.want.en_w  = en[0];
        v.want.rs1   = rs1;
        v.want.rs2   = rs2;
        v.want.rd    = rd;
        vectors.push_back(v);
    endtask

    `include "decoder_tb_vectors.svh"

    task automatic check_word(input int row, input string name,
                              input rv32_pkg::word_t got, input rv32_pkg::word_t want);
        if (got !== want) begin
            $display("[FAIL] row %0d %s: got 0x%h, expected 0x%h", row, name, got, want);
            row_errors++;
        end
    endtask

    task automatic check_op(input int row, input string name,
                            input rv32_pkg::oper_t got, input rv32_pkg::oper_t want);
        if (got !== want) begin
            $display("[FAIL] row %0d %s: got 0x%h, expected 0x%h", row, name, got, want);
            row_errors++;
        end
    endtask

    task automatic check_reg(input int row, input string name,
                             input rv32_pkg::regaddr_t got, input rv32_pkg::regaddr_t want);
        if (got !== want) begin
            $display("[FAIL] row %0d %s: got 0x%h, expected 0x%h", row, name, got, want);
            row_errors++;
        end
    endtask

    task automatic check_flag(input int row, input string name, input logic got,
                              input logic want);
        if (got !== want) begin
            $display("[FAIL] row %0d %s: got 0x%h, expected 0x%h", row, name, got, want);
            row_errors++;
        end
    endtask

    task automatic check_row(input int row, input rv32_pkg::dec_out_t want);
        row_errors = 0;
        check_word(row, "dec_o.pc", dec_o.pc, want.pc);
        check_op(row, "dec_o.op", dec_o.op, want.op);
        check_word(row, "dec_o.imm", dec_o.imm, want.imm);
        check_flag(row, "dec_o.en_rx", dec_o.en_rx, want.en_rx);
        check_flag(row, "dec_o.en_ry", dec_o.en_ry, want.en_ry);
        check_flag(row, "dec_o.en_w", dec_o.en_w, want.en_w);
        check_reg(row, "dec_o.rs1", dec_o.rs1, want.rs1);
        check_reg(row, "dec_o.rs2", dec_o.rs2, want.rs2);
        check_reg(row, "dec_o.rd", dec_o.rd, want.rd);
        if (row_errors == 0) begin
            pass_count++;
            $display("row %0d ok: pc 0x%h op 0x%h", row, dec_o.pc, dec_o.op);
        end else begin
            fail_count++;
            $display("row %0d had %0d mismatches", row, row_errors);
        end
    endtask

    task automatic drive_row(input vector_t v);
        rdy_i   = v.ctl[2];
        issue_i = v.ctl[1];
        hit_i   = v.ctl[0];
        pc_i    = v.pc;
        inst_i  = v.inst;
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        rdy_i       = 1'b0;
        issue_i     = 1'b0;
        hit_i       = 1'b0;
        pc_i        = '0;
        inst_i      = '0;
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;
        load_vectors();
        cycle_limit = 4 * vectors.size() + 20;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // each row is checked one edge after it was driven.
        for (int i = 0; i <= vectors.size(); i++) begin
            @(posedge clk);
            #1;
            if (i > 0) check_row(i - 1, vectors[i - 1].want);
            if (i < vectors.size()) drive_row(vectors[i]);
        end
        $display("rows passed: %0d, rows failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: src/decoder.sv
module decoder (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy_i,
    input  logic               issue_i,
    input  logic               hit_i,
    input  rv32_pkg::addr_t    pc_i,
    input  rv32_pkg::inst_t    inst_i,
    output rv32_pkg::dec_out_t dec_o
);

    rv32_pkg::addr_t    pc_q;
    rv32_pkg::inst_t    inst_q;
    rv32_pkg::opcode_t  opcode;
    rv32_pkg::fmt_dec_t dec_i;
    rv32_pkg::fmt_dec_t dec_r;
    rv32_pkg::fmt_dec_t dec_s;
    rv32_pkg::fmt_dec_t dec_b;
    rv32_pkg::fmt_dec_t dec_uj;
    rv32_pkg::fmt_dec_t sel;
    logic               use_rx;
    logic               use_ry;
    logic               use_w;
    logic               en_rx;
    logic               en_ry;
    logic               en_w;

    // rdy freezes the held instruction and a miss loads a bubble.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q   <= '0;
            inst_q <= '0;
        end else if (rdy_i && issue_i) begin
            if (hit_i) begin
                pc_q   <= pc_i;
                inst_q <= inst_i;
            end else begin
                pc_q   <= '0;
                inst_q <= rv32_pkg::INST_NOP;
            end
        end
    end

    decode_fmt_i  u_fmt_i  (.inst_i(inst_q), .dec_o(dec_i));
    decode_fmt_r  u_fmt_r  (.inst_i(inst_q), .dec_o(dec_r));
    decode_fmt_s  u_fmt_s  (.inst_i(inst_q), .dec_o(dec_s));
    decode_fmt_b  u_fmt_b  (.inst_i(inst_q), .dec_o(dec_b));
    decode_fmt_uj u_fmt_uj (.inst_i(inst_q), .dec_o(dec_uj));

    assign opcode = inst_q[6:0];

    always_comb begin
        sel    = '0;
        use_rx = 1'b0;
        use_ry = 1'b0;
        use_w  = 1'b0;
        case (opcode)
            rv32_pkg::OPC_IMM, rv32_pkg::OPC_LOAD: begin
                sel    = dec_i;
                use_rx = 1'b1;
                use_w  = 1'b1;
            end
            rv32_pkg::OPC_OP: begin
                sel    = dec_r;
                use_rx = 1'b1;
                use_ry = 1'b1;
                use_w  = 1'b1;
            end
            rv32_pkg::OPC_STORE: begin
                sel    = dec_s;
                use_rx = 1'b1;
                use_ry = 1'b1;
            end
            rv32_pkg::OPC_BRANCH: begin
                sel    = dec_b;
                use_rx = 1'b1;
                use_ry = 1'b1;
            end
            rv32_pkg::OPC_LUI, rv32_pkg::OPC_AUIPC, rv32_pkg::OPC_JAL: begin
                sel   = dec_uj;
                use_w = 1'b1;
            end
            rv32_pkg::OPC_JALR: begin
                sel    = dec_uj;
                use_rx = 1'b1;
                use_w  = 1'b1;
            end
            default: sel = '0;
        endcase
    end

    // an illegal or unknown instruction becomes a NOP.
    assign en_rx = use_rx & sel.legal;
    assign en_ry = use_ry & sel.legal;
    assign en_w  = use_w & sel.legal;

    always_comb begin
        dec_o       = '0;
        dec_o.pc    = pc_q;
        dec_o.op    = sel.legal ? sel.op : rv32_pkg::OP_NOP;
        dec_o.imm   = sel.legal ? sel.imm : '0;
        dec_o.en_rx = en_rx;
        dec_o.en_ry = en_ry;
        dec_o.en_w  = en_w;
        dec_o.rs1   = en_rx ? sel.rs1 : '0;
        dec_o.rs2   = en_ry ? sel.rs2 : '0;
        dec_o.rd    = en_w ? sel.rd : '0;
    end

    // formats without a destination already deliver a cleared rd field.
    a_rd_zero: assert property (@(posedge clk) disable iff (rst)
        !en_w |-> (sel.rd == '0))
        else $error("selected rd is nonzero while en_w is low");

    // the cleared register holds opcode 0, which no group claims.
    a_reset_nop: assert property (@(posedge clk)
        rst |=> !(dec_o.en_rx || dec_o.en_ry || dec_o.en_w))
        else $error("enables active one cycle after reset");

endmodule

// File: src/decode_fmt_uj.sv
module decode_fmt_uj (
    input  rv32_pkg::inst_t    inst_i,
    output rv32_pkg::fmt_dec_t dec_o
);

    rv32_pkg::opcode_t opcode;
    rv32_pkg::word_t   imm_u;
    rv32_pkg::word_t   imm_j;
    rv32_pkg::word_t   imm_i;

    assign opcode = inst_i[6:0];
    assign imm_u  = {inst_i[31:12], 12'h000};
    assign imm_j  = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                     inst_i[20], inst_i[30:21], 1'b0};
    assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};

    // this block owns four opcodes, so it has to tell them apart itself.
    always_comb begin
        dec_o = '0;
        case (opcode)
            rv32_pkg::OPC_LUI: begin
                dec_o.legal = 1'b1;
                dec_o.op    = rv32_pkg::OP_LUI;
                dec_o.imm   = imm_u;
                dec_o.rd    = inst_i[11:7];
            end
            rv32_pkg::OPC_AUIPC: begin
                dec_o.legal = 1'b1;
                dec_o.op    = rv32_pkg::OP_AUIPC;
                dec_o.imm   = imm_u;
                dec_o.rd    = inst_i[11:7];
            end
            rv32_pkg::OPC_JAL: begin
                dec_o.legal = 1'b1;
                dec_o.op    = rv32_pkg::OP_JAL;
                dec_o.imm   = imm_j;
                dec_o.rd    = inst_i[11:7];
            end
            rv32_pkg::OPC_JALR: begin
                if (inst_i[14:12] == 3'd0) begin
                    dec_o.legal = 1'b1;
                    dec_o.op    = rv32_pkg::OP_JALR;
                    dec_o.imm   = imm_i;
                    dec_o.rs1   = inst_i[19:15];
                    dec_o.rd    = inst_i[11:7];
                end
            end
            default: dec_o = '0;
        endcase
    end

endmodule

// File: src/decode_fmt_b.sv
module decode_fmt_b (
    input  rv32_pkg::inst_t    inst_i,
    output rv32_pkg::fmt_dec_t dec_o
);

    rv32_pkg::oper_t op;

    always_comb begin
        case (inst_i[14:12])
            3'd0: op = rv32_pkg::OP_BEQ;
            3'd1: op = rv32_pkg::OP_BNE;
            3'd4: op = rv32_pkg::OP_BLT;
            3'd5: op = rv32_pkg::OP_BGE;
            3'd6: op = rv32_pkg::OP_BLTU;
            3'd7: op = rv32_pkg::OP_BGEU;
            default: op = rv32_pkg::OP_NOP;
        endcase
    end

    always_comb begin
        dec_o = '0;
        if (op != rv32_pkg::OP_NOP) begin
            dec_o.legal = 1'b1;
            dec_o.op    = op;
            dec_o.imm   = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                           inst_i[30:25], inst_i[11:8], 1'b0};
            dec_o.rs1   = inst_i[19:15];
            dec_o.rs2   = inst_i[24:20];
        end
    end

    // branch targets are always halfword aligned.
    a_imm_aligned: assert property (@(inst_i) dec_o.legal |-> (dec_o.imm[0] == 1'b0))
        else $error("branch immediate has bit 0 set");

endmodule

// File: src/decode_fmt_s.sv
module decode_fmt_s (
    input  rv32_pkg::inst_t    inst_i,
    output rv32_pkg::fmt_dec_t dec_o
);

    rv32_pkg::oper_t op;

    always_comb begin
        case (inst_i[14:12])
            3'd0: op = rv32_pkg::OP_SB;
            3'd1: op = rv32_pkg::OP_SH;
            3'd2: op = rv32_pkg::OP_SW;
            default: op = rv32_pkg::OP_NOP;
        endcase
    end

    always_comb begin
        dec_o = '0;
        if (op != rv32_pkg::OP_NOP) begin
            dec_o.legal = 1'b1;
            dec_o.op    = op;
            // the store offset is split around the rd field.
            dec_o.imm   = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            dec_o.rs1   = inst_i[19:15];
            dec_o.rs2   = inst_i[24:20];
        end
    end

endmodule

// File: src/decode_fmt_r.sv
module decode_fmt_r (
    input  rv32_pkg::inst_t    inst_i,
    output rv32_pkg::fmt_dec_t dec_o
);

    logic [2:0]      funct3;
    logic [6:0]      funct7;
    rv32_pkg::oper_t op;

    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    always_comb begin
        op = rv32_pkg::OP_NOP;
        if (funct7 == rv32_pkg::FUNCT7_BASE) begin
            case (funct3)
                3'd0: op = rv32_pkg::OP_ADD;
                3'd1: op = rv32_pkg::OP_SLL;
                3'd2: op = rv32_pkg::OP_SLT;
                3'd3: op = rv32_pkg::OP_SLTU;
                3'd4: op = rv32_pkg::OP_XOR;
                3'd5: op = rv32_pkg::OP_SRL;
                3'd6: op = rv32_pkg::OP_OR;
                default: op = rv32_pkg::OP_AND;
            endcase
        end else if (funct7 == rv32_pkg::FUNCT7_ALT) begin
            // only sub and sra exist with the alternate funct7.
            if (funct3 == 3'd0) op = rv32_pkg::OP_SUB;
            else if (funct3 == 3'd5) op = rv32_pkg::OP_SRA;
        end
    end

    always_comb begin
        dec_o = '0;
        if (op != rv32_pkg::OP_NOP) begin
            dec_o.legal = 1'b1;
            dec_o.op    = op;
            dec_o.rs1   = inst_i[19:15];
            dec_o.rs2   = inst_i[24:20];
            dec_o.rd    = inst_i[11:7];
        end
    end

endmodule

// File: src/decode_fmt_i.sv
module decode_fmt_i (
    input  rv32_pkg::inst_t    inst_i,
    output rv32_pkg::fmt_dec_t dec_o
);

    logic            is_load;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    rv32_pkg::oper_t op;

    assign is_load = (inst_i[6:0] == rv32_pkg::OPC_LOAD);
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];

    always_comb begin
        op = rv32_pkg::OP_NOP;
        if (is_load) begin
            case (funct3)
                3'd0: op = rv32_pkg::OP_LB;
                3'd1: op = rv32_pkg::OP_LH;
                3'd2: op = rv32_pkg::OP_LW;
                3'd4: op = rv32_pkg::OP_LBU;
                3'd5: op = rv32_pkg::OP_LHU;
                default: op = rv32_pkg::OP_NOP;
            endcase
        end else begin
            case (funct3)
                3'd0: op = rv32_pkg::OP_ADDI;
                3'd2: op = rv32_pkg::OP_SLTI;
                3'd3: op = rv32_pkg::OP_SLTIU;
                3'd4: op = rv32_pkg::OP_XORI;
                3'd6: op = rv32_pkg::OP_ORI;
                3'd7: op = rv32_pkg::OP_ANDI;
                3'd1: if (funct7 == rv32_pkg::FUNCT7_BASE) op = rv32_pkg::OP_SLLI;
                3'd5: begin
                    // the upper immediate bits pick the shift kind.
                    if (funct7 == rv32_pkg::FUNCT7_BASE) op = rv32_pkg::OP_SRLI;
                    else if (funct7 == rv32_pkg::FUNCT7_ALT) op = rv32_pkg::OP_SRAI;
                end
                default: op = rv32_pkg::OP_NOP;
            endcase
        end
    end

    always_comb begin
        dec_o = '0;
        if (op != rv32_pkg::OP_NOP) begin
            dec_o.legal = 1'b1;
            dec_o.op    = op;
            // shamt stays in imm[4:0] for the shifts.
            dec_o.imm   = {{20{inst_i[31]}}, inst_i[31:20]};
            dec_o.rs1   = inst_i[19:15];
            dec_o.rd    = inst_i[11:7];
        end
    end

endmodule

// File: src/rv32_pkg.sv
package rv32_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int OPER_W = 6;

    typedef logic [XLEN-1:0]   addr_t;
    typedef logic [XLEN-1:0]   inst_t;
    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] regaddr_t;
    typedef logic [OPER_W-1:0] oper_t;
    typedef logic [6:0]        opcode_t;

    // operation codes seen by the rest of the core.
    localparam oper_t OP_NOP   = 6'd0;
    localparam oper_t OP_LUI   = 6'd1;
    localparam oper_t OP_AUIPC = 6'd2;
    localparam oper_t OP_JAL   = 6'd3;
    localparam oper_t OP_JALR  = 6'd4;
    localparam oper_t OP_BEQ   = 6'd5;
    localparam oper_t OP_BNE   = 6'd6;
    localparam oper_t OP_BLT   = 6'd7;
    localparam oper_t OP_BGE   = 6'd8;
    localparam oper_t OP_BLTU  = 6'd9;
    localparam oper_t OP_BGEU  = 6'd10;
    localparam oper_t OP_LB    = 6'd11;
    localparam oper_t OP_LH    = 6'd12;
    localparam oper_t OP_LW    = 6'd13;
    localparam oper_t OP_LBU   = 6'd14;
    localparam oper_t OP_LHU   = 6'd15;
    localparam oper_t OP_SB    = 6'd16;
    localparam oper_t OP_SH    = 6'd17;
    localparam oper_t OP_SW    = 6'd18;
    localparam oper_t OP_ADDI  = 6'd19;
    localparam oper_t OP_SLTI  = 6'd20;
    localparam oper_t OP_SLTIU = 6'd21;
    localparam oper_t OP_XORI  = 6'd22;
    localparam oper_t OP_ORI   = 6'd23;
    localparam oper_t OP_ANDI  = 6'd24;
    localparam oper_t OP_SLLI  = 6'd25;
    localparam oper_t OP_SRLI  = 6'd26;
    localparam oper_t OP_SRAI  = 6'd27;
    localparam oper_t OP_ADD   = 6'd28;
    localparam oper_t OP_SUB   = 6'd29;
    localparam oper_t OP_SLL   = 6'd30;
    localparam oper_t OP_SLT   = 6'd31;
    localparam oper_t OP_SLTU  = 6'd32;
    localparam oper_t OP_XOR   = 6'd33;
    localparam oper_t OP_SRL   = 6'd34;
    localparam oper_t OP_SRA   = 6'd35;
    localparam oper_t OP_OR    = 6'd36;
    localparam oper_t OP_AND   = 6'd37;

    // major opcodes, instruction bits 6:0.
    localparam opcode_t OPC_IMM    = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    localparam logic [6:0] FUNCT7_BASE = 7'h00;
    localparam logic [6:0] FUNCT7_ALT  = 7'h20;

    // addi x0, x0, 0.
    localparam inst_t INST_NOP = 32'h0000_0013;

    typedef struct packed {
        logic     legal;
        oper_t    op;
        word_t    imm;
        regaddr_t rs1;
        regaddr_t rs2;
        regaddr_t rd;
    } fmt_dec_t;

    typedef struct packed {
        addr_t    pc;
        oper_t    op;
        word_t    imm;
        logic     en_rx;
        logic     en_ry;
        logic     en_w;
        regaddr_t rs1;
        regaddr_t rs2;
        regaddr_t rd;
    } dec_out_t;

endpackage
